//--- fsab_mem.f
+incdir+verification
verilog/fsab_pkg.sv
verilog/fsab_if.sv
verilog/fsab_req_fifo.sv
verilog/fsab_data_fifo.sv
verilog/fsab_mem_ctrl.sv
verilog/fsab_mem.sv
verification/tb_fsab_mem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the FSAB memory testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fsab_mem -f fsab_mem.f -o tb_fsab_mem &&
	./obj_dir/tb_fsab_mem | tee /dev/stderr | grep -q "^Regression passed$" ||
	{ echo "Simulation did not pass"; exit 1; }

//--- verification/tb_fsab_tasks.svh
`ifndef TB_FSAB_TASKS_SVH
`define TB_FSAB_TASKS_SVH
`default_nettype none

task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
	if (got !== exp) begin
		error_count++;
		$display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
	end
endtask

// 64-bit xorshift step
function automatic logic [63:0] xorshift(input logic [63:0] x);
	logic [63:0] s;
	s = x ^ (x << 13);
	s = s ^ (s >> 7);
	return s ^ (s << 17);
endfunction

function automatic int credits_free();
	return FSAB_INITIAL_CREDITS - headers_sent + credit_pulses;
endfunction

function automatic int word_index(input logic [FSAB_ADDR_W-1:0] addr);
	return int'(addr / FSAB_WORD_BYTES) % MEM_WORDS;  // Low byte bits dropped
endfunction

// Random write words under one shared mask
task automatic load_random(input int len, input logic [FSAB_MASK_W-1:0] mask);
	wr_buf.delete();
	mask_buf.delete();
	for (int i = 0; i < len; i++) begin
		rng_state = xorshift(rng_state);
		wr_buf.push_back(rng_state);
		mask_buf.push_back(mask);
	end
endtask

task automatic wait_credit(input int need);
	int n;
	n = 0;
	while (credits_free() < need && n < TIMEOUT) begin
		@(negedge clk);
		n++;
	end
	if (credits_free() < need) begin
		timeout_count++;
		$display("Timeout at %0t ns: credits did not come back", $time);
	end
endtask

// Sends wr_buf as one burst with the header on the first beat
task automatic send_write(input logic [FSAB_ADDR_W-1:0] addr);
	int idx;
	wait_credit(1);
	headers_sent++;
	for (int i = 0; i < wr_buf.size(); i++) begin
		fsabo_valid = 1'b1;
		fsabo_mode  = FSAB_WRITE;
		fsabo_addr  = addr;
		fsabo_len   = FSAB_LEN_W'(wr_buf.size());
		fsabo_data  = wr_buf[i];
		fsabo_mask  = mask_buf[i];
		idx = (word_index(addr) + i) % MEM_WORDS;
		for (int b = 0; b < FSAB_MASK_W; b++) begin
			if (mask_buf[i][b])  // Only enabled bytes change
				shadow[idx * FSAB_WORD_BYTES + b] = wr_buf[i][b*8 +: 8];
		end
		@(negedge clk);
	end
	fsabo_valid = 1'b0;
endtask

// One header beat that takes its expected words from the shadow
task automatic send_read(input logic [FSAB_ADDR_W-1:0] addr, input logic [FSAB_DID_W-1:0] did,
		input logic [FSAB_DID_W-1:0] subdid, input int len);
	logic [FSAB_DATA_W-1:0] word;
	int idx;
	wait_credit(1);
	headers_sent++;
	fsabo_valid  = 1'b1;
	fsabo_mode   = FSAB_READ;
	fsabo_did    = did;
	fsabo_subdid = subdid;
	fsabo_addr   = addr;
	fsabo_len    = FSAB_LEN_W'(len);
	fsabo_data   = '0;  // Dummy word
	fsabo_mask   = '0;
	for (int i = 0; i < len; i++) begin
		idx = (word_index(addr) + i) % MEM_WORDS;
		for (int b = 0; b < FSAB_MASK_W; b++)
			word[b*8 +: 8] = shadow[idx * FSAB_WORD_BYTES + b];
		exp_data.push_back(word);
		exp_ids.push_back({did, subdid});
	end
	@(negedge clk);
	fsabo_valid = 1'b0;
endtask

task automatic collect_read(input int count);
	int n;
	for (int k = 0; k < count; k++) begin
		n = 0;
		while (got_data.size() == 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (got_data.size() == 0) begin
			timeout_count++;
			$display("Timeout at %0t ns: read beat %0d of %0d never came back", $time, k, count);
			exp_data.delete();
			exp_ids.delete();
			return;
		end
		check_value(got_data.pop_front(), exp_data.pop_front(), "read data");
		check_value(64'(got_ids.pop_front()), 64'(exp_ids.pop_front()), "read ids");
	end
endtask

`default_nettype wire
`endif

//--- verification/tb_fsab_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fsab_mem import fsab_pkg::*; ();

	localparam int MEM_WORDS = 4096;
	localparam int TIMEOUT   = 200;  // Cycles allowed for any one wait

	logic                    clk;
	logic                    Nrst;
	logic                    fsabo_valid;
	fsab_mode_e              fsabo_mode;
	logic [FSAB_DID_W-1:0]   fsabo_did;
	logic [FSAB_DID_W-1:0]   fsabo_subdid;
	logic [FSAB_ADDR_W-1:0]  fsabo_addr;
	logic [FSAB_LEN_W-1:0]   fsabo_len;
	logic [FSAB_DATA_W-1:0]  fsabo_data;
	logic [FSAB_MASK_W-1:0]  fsabo_mask;
	logic                    fsabo_credit;
	logic                    fsabi_valid;
	logic [FSAB_DID_W-1:0]   fsabi_did;
	logic [FSAB_DID_W-1:0]   fsabi_subdid;
	logic [FSAB_DATA_W-1:0]  fsabi_data;

	int                      headers_sent  = 0;
	int                      credit_pulses = 0;
	int                      error_count   = 0;
	int                      timeout_count = 0;
	logic [63:0]             rng_state;

	logic [7:0]              shadow [int];  // Byte-wide model of storage
	logic [FSAB_DATA_W-1:0]  wr_buf [$];
	logic [FSAB_MASK_W-1:0]  mask_buf [$];
	logic [FSAB_DATA_W-1:0]  exp_data [$];
	logic [2*FSAB_DID_W-1:0] exp_ids [$];   // {did, subdid}
	logic [FSAB_DATA_W-1:0]  got_data [$];
	logic [2*FSAB_DID_W-1:0] got_ids [$];

	fsab_mem #(
		.MEM_WORDS (MEM_WORDS)
	) i_fsab_mem (
		.clk          (clk),
		.Nrst         (Nrst),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Counts credit pulses and flags any beyond the headers sent
	always @(posedge clk) begin
		if (Nrst && fsabo_credit) begin
			credit_pulses = credit_pulses + 1;
			check_value(64'(credit_pulses <= headers_sent), 64'd1, "credit count above initial");
		end
	end

	always @(posedge clk) begin
		if (Nrst && fsabi_valid) begin  // Read return monitor
			got_data.push_back(fsabi_data);
			got_ids.push_back({fsabi_did, fsabi_subdid});
		end
	end

	task automatic single_write_read();
		load_random(1, 8'hFF);
		send_write(31'h100);
		send_read(31'h100, 4'h3, 4'h5, 1);
		collect_read(1);
	endtask

	task automatic partial_mask_merge();
		load_random(1, 8'hFF);
		send_write(31'h200);
		load_random(1, 8'h3C);  // Middle four bytes only
		send_write(31'h200);
		send_read(31'h200, 4'h6, 4'h9, 1);
		collect_read(1);
	endtask

	task automatic burst_write_read();
		load_random(8, 8'hFF);
		send_write(31'h400);
		send_read(31'h400, 4'h1, 4'h2, 8);
		collect_read(8);
		repeat (8) @(negedge clk);  // Window for stray beats
		check_value(64'(got_data.size()), 64'd0, "extra beats after burst read");
	endtask

	task automatic credit_exhaustion();
		int hdr_base;
		int pulse_base;
		wait_credit(FSAB_INITIAL_CREDITS);
		hdr_base   = headers_sent;
		pulse_base = credit_pulses;
		for (int i = 0; i < FSAB_INITIAL_CREDITS; i++)
			send_read(31'h400, FSAB_DID_W'(i), FSAB_DID_W'(15 - i), 8);
		load_random(2, 8'hFF);
		send_write(31'h600);  // Needs a returned credit first
		// Second read is still queued behind the first 8-word read
		check_value(64'(credits_free()), 64'd0, "credits left after back-to-back requests");
		wait_credit(FSAB_INITIAL_CREDITS);
		check_value(64'(credit_pulses - pulse_base), 64'(headers_sent - hdr_base),
			"credit pulses against requests");
		collect_read(FSAB_INITIAL_CREDITS * 8);
	endtask

	task automatic mixed_id_reads();
		load_random(6, 8'hFF);
		send_write(31'h800);
		load_random(4, 8'hA5);
		send_write(31'h810);
		send_read(31'h800, 4'h7, 4'h1, 2);
		load_random(1, 8'h0F);
		send_write(31'h808);  // Lands between the first and second read
		send_read(31'h808, 4'h9, 4'hC, 5);
		send_read(31'h828, 4'hF, 4'h3, 1);
		collect_read(8);
	endtask

	initial begin
		Nrst         = 1'b0;
		fsabo_valid  = 1'b0;
		fsabo_mode   = FSAB_READ;
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		fsabo_data   = '0;
		fsabo_mask   = '0;
		rng_state    = 64'd91;
		repeat (16) begin
			@(negedge clk);
			check_value(64'(fsabo_credit), 64'd0, "credit during reset");
			check_value(64'(fsabi_valid), 64'd0, "read valid during reset");
		end
		Nrst = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_value(64'(fsabo_credit), 64'd0, "credit after reset");
			check_value(64'(fsabi_valid), 64'd0, "read valid after reset");
		end

		single_write_read();
		partial_mask_merge();
		burst_write_read();
		credit_exhaustion();
		mixed_id_reads();

		wait_credit(FSAB_INITIAL_CREDITS);
		check_value(64'(got_data.size()), 64'd0, "unclaimed read beats");
		$display("Finished with %0d errors and %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	`include "tb_fsab_tasks.svh"

endmodule

`default_nettype wire

//--- verilog/fsab_data_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fsab_data_fifo import fsab_pkg::*; (
	input  logic                   clk,
	input  logic                   Nrst,

	input  logic                   fsabo_valid,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,

	fsab_wdata_if.fifo_side        wd
);

	localparam int PTR_W = $clog2(FSAB_DFIF_DEPTH);

	logic [FSAB_DATA_W-1:0] data_mem [FSAB_DFIF_DEPTH];
	logic [FSAB_MASK_W-1:0] mask_mem [FSAB_DFIF_DEPTH];

	logic [PTR_W:0]         wptr;
	logic [PTR_W:0]         rptr;
	logic                   empty;
	logic                   full;

	assign empty = (wptr == rptr);
	assign full  = (wptr[PTR_W] != rptr[PTR_W]) && (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (fsabo_valid)  // Every beat, header or not, carries a word
				wptr <= wptr + 1'b1;
			if (wd.wd_pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fsabo_valid) begin
			data_mem[wptr[PTR_W-1:0]] <= fsabo_data;
			mask_mem[wptr[PTR_W-1:0]] <= fsabo_mask;
		end
	end

	// Oldest beat stays on the outputs until popped
	assign wd.wd_valid = !empty;
	assign wd.wd_data  = data_mem[rptr[PTR_W-1:0]];
	assign wd.wd_mask  = mask_mem[rptr[PTR_W-1:0]];

	// Depth covers a full burst for every outstanding credit
	a_no_wr_full: assert property (@(posedge clk) disable iff (!Nrst) fsabo_valid |-> !full)
		else $error("Data FIFO written while full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!Nrst) wd.wd_pop |-> !empty)
		else $error("Data FIFO popped while empty");

endmodule

`default_nettype wire

//--- verilog/fsab_if.sv
`timescale 1ns/1ps
`default_nettype none

// Oldest queued request header from the request FIFO to the controller
interface fsab_req_if import fsab_pkg::*; ();
	logic                   req_valid;  // Header FIFO non-empty
	fsab_mode_e             req_mode;
	logic [FSAB_DID_W-1:0]  req_did;
	logic [FSAB_DID_W-1:0]  req_subdid;
	logic [FSAB_ADDR_W-1:0] req_addr;
	logic [FSAB_LEN_W-1:0]  req_len;
	logic                   req_pop;    // Next header shows up one cycle later

	modport fifo_side (
		output req_valid, req_mode, req_did, req_subdid, req_addr, req_len,
		input  req_pop
	);

	modport ctrl_side (
		input  req_valid, req_mode, req_did, req_subdid, req_addr, req_len,
		output req_pop
	);
endinterface

// Oldest queued data beat from the data FIFO to the controller
interface fsab_wdata_if import fsab_pkg::*; ();
	logic                   wd_valid;  // Data FIFO non-empty
	logic [FSAB_DATA_W-1:0] wd_data;
	logic [FSAB_MASK_W-1:0] wd_mask;
	logic                   wd_pop;

	modport fifo_side (
		output wd_valid, wd_data, wd_mask,
		input  wd_pop
	);

	modport ctrl_side (
		input  wd_valid, wd_data, wd_mask,
		output wd_pop
	);
endinterface

`default_nettype wire

//--- verilog/fsab_mem.sv
`timescale 1ns/1ps
`default_nettype none

module fsab_mem import fsab_pkg::*; #(
	parameter int MEM_WORDS = 4096  // Storage size in words as a power of two
) (
	input  logic                   clk,
	input  logic                   Nrst,

	// Inbound requests
	input  logic                   fsabo_valid,
	input  fsab_mode_e             fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,
	input  logic [FSAB_DATA_W-1:0] fsabo_data,
	input  logic [FSAB_MASK_W-1:0] fsabo_mask,
	output logic                   fsabo_credit,

	// Read returns without back-pressure
	output logic                   fsabi_valid,
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);

	fsab_req_if   req_bus ();
	fsab_wdata_if wd_bus ();

	// Headers only
	fsab_req_fifo i_req_fifo (
		.clk          (clk),
		.Nrst         (Nrst),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.req          (req_bus.fifo_side)
	);

	// One entry per valid beat
	fsab_data_fifo i_data_fifo (
		.clk         (clk),
		.Nrst        (Nrst),
		.fsabo_valid (fsabo_valid),
		.fsabo_data  (fsabo_data),
		.fsabo_mask  (fsabo_mask),
		.wd          (wd_bus.fifo_side)
	);

	fsab_mem_ctrl #(
		.MEM_WORDS (MEM_WORDS)
	) i_mem_ctrl (
		.clk          (clk),
		.Nrst         (Nrst),
		.req          (req_bus.ctrl_side),
		.wd           (wd_bus.ctrl_side),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

endmodule

`default_nettype wire

//--- verilog/fsab_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fsab_mem_ctrl import fsab_pkg::*; #(
	parameter int MEM_WORDS = 4096
) (
	input  logic                   clk,
	input  logic                   Nrst,

	fsab_req_if.ctrl_side          req,
	fsab_wdata_if.ctrl_side        wd,

	output logic                   fsabo_credit,

	output logic                   fsabi_valid,
	output logic [FSAB_DID_W-1:0]  fsabi_did,
	output logic [FSAB_DID_W-1:0]  fsabi_subdid,
	output logic [FSAB_DATA_W-1:0] fsabi_data
);

	localparam int IDX_W      = $clog2(MEM_WORDS);
	localparam int WORD_SHIFT = $clog2(FSAB_WORD_BYTES);
	localparam int BYTE_W     = FSAB_DATA_W / FSAB_MASK_W;

	typedef enum logic [1:0] {
		IDLE,   // Waiting to pop the next header
		HDR,    // First word of the popped request
		WRITE,  // Remaining write words, paced by the data FIFO
		READ    // Remaining read words
	} fsab_ctrl_state_e;

	fsab_ctrl_state_e state;

	logic [FSAB_DATA_W-1:0] mem [MEM_WORDS];

	fsab_mode_e             cur_mode;
	logic [FSAB_DID_W-1:0]  cur_did;
	logic [FSAB_DID_W-1:0]  cur_subdid;
	logic [IDX_W-1:0]       cur_idx;   // Word address of the next access
	logic [FSAB_LEN_W-1:0]  len_rem;   // Words left counting the current one
	logic [FSAB_DATA_W-1:0] hdr_data;  // Word that rode along with the header
	logic [FSAB_MASK_W-1:0] hdr_mask;

	logic                   hdr_take;
	logic                   wd_beat;
	logic                   mem_we;
	logic                   rd_beat;
	logic                   step;
	logic                   last_word;
	logic [FSAB_DATA_W-1:0] wr_data;
	logic [FSAB_MASK_W-1:0] wr_mask;
	logic [FSAB_DATA_W-1:0] merged;

	// Header and its first data entry always leave together
	assign hdr_take = (state == IDLE) && req.req_valid && wd.wd_valid;
	assign wd_beat  = (state == WRITE) && wd.wd_valid;

	assign req.req_pop = hdr_take;
	assign wd.wd_pop   = hdr_take || wd_beat;

	assign mem_we    = ((state == HDR) && (cur_mode == FSAB_WRITE)) || wd_beat;
	assign rd_beat   = ((state == HDR) && (cur_mode == FSAB_READ)) || (state == READ);
	assign step      = mem_we || rd_beat;
	assign last_word = (len_rem <= FSAB_LEN_W'(1));

	assign wr_data = (state == HDR) ? hdr_data : wd.wd_data;
	assign wr_mask = (state == HDR) ? hdr_mask : wd.wd_mask;

	// Byte merge against the current contents
	always_comb begin
		merged = mem[cur_idx];
		for (int b = 0; b < FSAB_MASK_W; b++) begin
			if (wr_mask[b])
				merged[b*BYTE_W +: BYTE_W] = wr_data[b*BYTE_W +: BYTE_W];
		end
	end

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			state        <= IDLE;
			cur_mode     <= FSAB_READ;
			len_rem      <= '0;
			fsabo_credit <= 1'b0;
			fsabi_valid  <= 1'b0;
		end else begin
			fsabo_credit <= hdr_take;  // One credit back per popped header
			fsabi_valid  <= rd_beat;

			case (state)
				IDLE: begin
					if (hdr_take) begin
						state    <= HDR;
						cur_mode <= req.req_mode;
						len_rem  <= req.req_len;
					end
				end
				HDR: begin
					len_rem <= len_rem - 1'b1;
					if (last_word)
						state <= IDLE;
					else
						state <= (cur_mode == FSAB_WRITE) ? WRITE : READ;
				end
				WRITE: begin
					if (wd_beat) begin  // Stall until the next word arrives
						len_rem <= len_rem - 1'b1;
						if (last_word)
							state <= IDLE;
					end
				end
				READ: begin
					len_rem <= len_rem - 1'b1;
					if (last_word)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_take) begin
			cur_did    <= req.req_did;
			cur_subdid <= req.req_subdid;
			cur_idx    <= req.req_addr[WORD_SHIFT +: IDX_W];  // Byte address to word index
			hdr_data   <= wd.wd_data;
			hdr_mask   <= wd.wd_mask;
		end else if (step) begin
			cur_idx <= cur_idx + 1'b1;
		end

		if (mem_we)
			mem[cur_idx] <= merged;

		if (rd_beat) begin
			fsabi_data   <= mem[cur_idx];
			fsabi_did    <= cur_did;
			fsabi_subdid <= cur_subdid;
		end
	end

	// Write pops never eat into the next request's header word
	a_hdr_has_data: assert property (@(posedge clk) disable iff (!Nrst)
		req.req_valid |-> wd.wd_valid)
		else $error("Queued header has no data entry left");

endmodule

`default_nettype wire

//--- verilog/fsab_pkg.sv
`default_nettype none

package fsab_pkg;

	// Bus field widths
	parameter int FSAB_DATA_W = 64;
	parameter int FSAB_MASK_W = 8;   // One bit per data byte
	parameter int FSAB_ADDR_W = 31;  // Byte address
	parameter int FSAB_DID_W  = 4;   // Device id and sub-id
	parameter int FSAB_LEN_W  = 4;

	// Bursts run from 1 to FSAB_LEN_MAX words
	parameter int FSAB_LEN_MAX = 8;

	// Credits owned by the master after reset and the header FIFO depth
	parameter int FSAB_INITIAL_CREDITS = 4;

	// Worst case data backlog is a full burst for every credited request
	parameter int FSAB_DFIF_DEPTH = FSAB_INITIAL_CREDITS * FSAB_LEN_MAX;

	// Low address bits below a word are ignored
	parameter int FSAB_WORD_BYTES = 8;

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

endpackage

`default_nettype wire

//--- verilog/fsab_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fsab_req_fifo import fsab_pkg::*; (
	input  logic                   clk,
	input  logic                   Nrst,

	input  logic                   fsabo_valid,
	input  fsab_mode_e             fsabo_mode,
	input  logic [FSAB_DID_W-1:0]  fsabo_did,
	input  logic [FSAB_DID_W-1:0]  fsabo_subdid,
	input  logic [FSAB_ADDR_W-1:0] fsabo_addr,
	input  logic [FSAB_LEN_W-1:0]  fsabo_len,

	fsab_req_if.fifo_side          req
);

	localparam int PTR_W = $clog2(FSAB_INITIAL_CREDITS);

	typedef struct packed {
		fsab_mode_e             mode;
		logic [FSAB_DID_W-1:0]  did;
		logic [FSAB_DID_W-1:0]  subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0]  len;
	} hdr_t;

	hdr_t hdr_mem [FSAB_INITIAL_CREDITS];

	// Extra pointer bit tells full from empty
	logic [PTR_W:0]        wptr;
	logic [PTR_W:0]        rptr;
	logic                  empty;
	logic                  full;

	logic [FSAB_LEN_W-1:0] beats_left;  // Data-only beats still due from the current write
	logic                  hdr_wr;
	hdr_t                  hdr_in;
	hdr_t                  hdr_out;

	assign empty = (wptr == rptr);
	assign full  = (wptr[PTR_W] != rptr[PTR_W]) && (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

	// Only the first beat of a request is a header
	assign hdr_wr = fsabo_valid && (beats_left == '0);

	assign hdr_in = '{mode: fsabo_mode, did: fsabo_did, subdid: fsabo_subdid,
	                  addr: fsabo_addr, len: fsabo_len};

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			beats_left <= '0;
		end else if (hdr_wr && fsabo_mode == FSAB_WRITE && fsabo_len > FSAB_LEN_W'(1)) begin
			beats_left <= fsabo_len - 1'b1;  // Header beat already carried word 0
		end else if (fsabo_valid && beats_left != '0) begin
			beats_left <= beats_left - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (hdr_wr)
				wptr <= wptr + 1'b1;
			if (req.req_pop)
				rptr <= rptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_wr)
			hdr_mem[wptr[PTR_W-1:0]] <= hdr_in;
	end

	// Show-ahead head of queue
	assign hdr_out        = hdr_mem[rptr[PTR_W-1:0]];
	assign req.req_valid  = !empty;
	assign req.req_mode   = hdr_out.mode;
	assign req.req_did    = hdr_out.did;
	assign req.req_subdid = hdr_out.subdid;
	assign req.req_addr   = hdr_out.addr;
	assign req.req_len    = hdr_out.len;

	// A master that respects its credits can never overrun this queue
	a_no_wr_full: assert property (@(posedge clk) disable iff (!Nrst) hdr_wr |-> !full)
		else $error("Request FIFO written while full");
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!Nrst) req.req_pop |-> !empty)
		else $error("Request FIFO popped while empty");

endmodule

`default_nettype wire
